//--- tl2umi.f
+incdir+include
logic/tl2umi_pkg.sv
logic/tl_mask_convert.sv
logic/tl2umi_req.sv
logic/umi_req_fifo.sv
logic/tl2umi_resp.sv
logic/tl2umi.sv
sim/tl2umi_checker.sv
sim/tl2umi_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f tl2umi.f --top-module tl2umi_tb -o tl2umi_sim
	./obj_dir/tl2umi_sim | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/tl2umi_tb.sv
// ****************************************
// Testbench: clock, reset, random A beats,
// UMI device model and run timeout
// ****************************************

`timescale 1ns/1ps
`include "tl2umi_defs.svh"

module tl2umi_tb;

    localparam int NUM_TXN = 400;
    localparam int TIMEOUT_CYCLES = NUM_TXN * 40;

    logic                 clk;
    logic                 nreset;
    tl2umi_pkg::umi_addr_t host_srcaddr;
    logic                 tl_a_valid;
    logic                 tl_a_ready;
    tl2umi_pkg::tl_a_t    tl_a;
    logic                 tl_d_valid;
    logic                 tl_d_ready;
    tl2umi_pkg::tl_d_t    tl_d;
    logic                 uhost_req_valid;
    logic                 uhost_req_ready;
    tl2umi_pkg::umi_pkt_t uhost_req;
    logic                 uhost_resp_valid;
    logic                 uhost_resp_ready;
    tl2umi_pkg::umi_pkt_t uhost_resp;
    logic                 run_done = 1'b0;
    int                   error_count;
    int                   cycle_count = 0;

    tl2umi tl2umi_i (
        .clk              (clk),
        .nreset           (nreset),
        .host_srcaddr     (host_srcaddr),
        .tl_a_valid       (tl_a_valid),
        .tl_a_ready       (tl_a_ready),
        .tl_a             (tl_a),
        .tl_d_valid       (tl_d_valid),
        .tl_d_ready       (tl_d_ready),
        .tl_d             (tl_d),
        .uhost_req_valid  (uhost_req_valid),
        .uhost_req_ready  (uhost_req_ready),
        .uhost_req        (uhost_req),
        .uhost_resp_valid (uhost_resp_valid),
        .uhost_resp_ready (uhost_resp_ready),
        .uhost_resp       (uhost_resp)
    );

    tl2umi_checker checker_i (
        .clk              (clk),
        .nreset           (nreset),
        .host_srcaddr     (host_srcaddr),
        .tl_a_valid       (tl_a_valid),
        .tl_a_ready       (tl_a_ready),
        .tl_a             (tl_a),
        .tl_d_valid       (tl_d_valid),
        .tl_d_ready       (tl_d_ready),
        .tl_d             (tl_d),
        .uhost_req_valid  (uhost_req_valid),
        .uhost_req_ready  (uhost_req_ready),
        .uhost_req        (uhost_req),
        .uhost_resp_valid (uhost_resp_valid),
        .uhost_resp_ready (uhost_resp_ready),
        .uhost_resp       (uhost_resp),
        .run_done         (run_done),
        .error_count      (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic tl2umi_pkg::data_t random_word();
        return {$urandom, $urandom};
    endfunction

    function automatic tl2umi_pkg::tl_a_t random_beat();
        tl2umi_pkg::tl_a_t      beat;
        int unsigned            kind;
        int unsigned            nbytes;
        tl2umi_pkg::byte_mask_t span;
        beat = '0;
        kind = $urandom % 16;
        beat.size = tl2umi_pkg::tl_size_t'($urandom % 4);
        nbytes = 1 << beat.size;
        beat.source = tl2umi_pkg::tl_source_t'($urandom);
        // Naturally aligned, so the lanes stay inside one word
        beat.address = tl2umi_pkg::tl_addr_t'(random_word())
            & ~tl2umi_pkg::tl_addr_t'(nbytes - 1);
        span = tl2umi_pkg::byte_mask_t'(((1 << nbytes) - 1) << beat.address[2:0]);
        beat.mask = span;
        beat.data = random_word();
        if (kind < 5) begin
            beat.opcode = `TL_A_GET;
        end else if (kind < 10) begin
            beat.opcode = ($urandom % 2 == 0) ? `TL_A_PUTFULL : `TL_A_PUTPARTIAL;
            if (beat.opcode == `TL_A_PUTPARTIAL) begin
                beat.mask = span & tl2umi_pkg::byte_mask_t'($urandom);
                if (beat.mask == '0) begin
                    beat.mask = span;
                end
            end
        end else if (kind < 15) begin
            if ($urandom % 2 == 0) begin
                beat.opcode = `TL_A_ARITH;
                beat.param = 3'($urandom % 5);
            end else begin
                beat.opcode = `TL_A_LOGICAL;
                beat.param = 3'($urandom % 4);
            end
        end else begin
            beat.opcode = 3'(5 + $urandom % 3);
        end
        return beat;
    endfunction

    // Device side answer, routed back through the request srcaddr
    function automatic tl2umi_pkg::umi_pkt_t respond_to(input tl2umi_pkg::umi_pkt_t req);
        tl2umi_pkg::umi_pkt_t resp;
        resp = '0;
        resp.dstaddr = req.srcaddr;
        resp.srcaddr = req.dstaddr;
        resp.cmd[`UMI_CMD_EOM] = 1'b1;
        if (req.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB] == `UMI_REQ_WRITE) begin
            resp.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB] = `UMI_RESP_WRITE;
        end else begin
            resp.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB] = `UMI_RESP_READ;
            resp.data = random_word();
        end
        return resp;
    endfunction

    task automatic send_beat(input tl2umi_pkg::tl_a_t beat);
        logic accepted;
        accepted = 1'b0;
        tl_a = beat;
        tl_a_valid = 1'b1;
        while (!accepted) begin
            @(negedge clk);
            accepted = tl_a_ready;
            @(posedge clk);
            #1;
        end
        tl_a_valid = 1'b0;
    endtask

    task automatic end_run(input logic hit_timeout);
        run_done = 1'b1;
        @(negedge clk);
        #1;
        if (error_count == 0 && !hit_timeout) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    initial begin
        int gap;
        void'($urandom(87100));
        nreset = 1'b0;
        tl_a_valid = 1'b0;
        tl_a = '0;
        host_srcaddr = random_word();
        repeat (3) @(posedge clk);
        #1;
        nreset = 1'b1;
        for (int n = 0; n < NUM_TXN; n++) begin
            send_beat(random_beat());
            gap = $urandom % 3;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        // Let the last transaction drain
        do begin
            @(negedge clk);
        end while (!tl_a_ready);
        repeat (4) @(posedge clk);
        end_run(1'b0);
    end

    initial begin : device_model
        tl2umi_pkg::umi_pkt_t req;
        logic                 taken;
        int                   delay;
        uhost_req_ready = 1'b0;
        uhost_resp_valid = 1'b0;
        uhost_resp = '0;
        wait (nreset === 1'b1);
        forever begin
            taken = 1'b0;
            while (!taken) begin
                uhost_req_ready = ($urandom % 4) != 0;
                @(negedge clk);
                taken = uhost_req_valid && uhost_req_ready;
                req = uhost_req;
                @(posedge clk);
                #1;
            end
            uhost_req_ready = 1'b0;
            delay = $urandom % 5;
            repeat (delay) begin
                @(posedge clk);
                #1;
            end
            uhost_resp = respond_to(req);
            uhost_resp_valid = 1'b1;
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = uhost_resp_ready;
                @(posedge clk);
                #1;
            end
            uhost_resp_valid = 1'b0;
        end
    end

    initial begin
        tl_d_ready = 1'b0;
        wait (nreset === 1'b1);
        forever begin
            tl_d_ready = ($urandom % 3) != 0;
            @(posedge clk);
            #1;
        end
    end

    initial begin
        wait (cycle_count == TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, the transactions did not complete", TIMEOUT_CYCLES);
        end_run(1'b1);
    end

endmodule

//--- sim/tl2umi_checker.sv
// ****************************************
// Checker: predicts UMI requests and D
// beats, compares them, counts errors
// ****************************************

`timescale 1ns/1ps
`include "tl2umi_defs.svh"

module tl2umi_checker (
    input  logic                  clk,
    input  logic                  nreset,
    input  tl2umi_pkg::umi_addr_t host_srcaddr,
    input  logic                  tl_a_valid,
    input  logic                  tl_a_ready,
    input  tl2umi_pkg::tl_a_t     tl_a,
    input  logic                  tl_d_valid,
    input  logic                  tl_d_ready,
    input  tl2umi_pkg::tl_d_t     tl_d,
    input  logic                  uhost_req_valid,
    input  logic                  uhost_req_ready,
    input  tl2umi_pkg::umi_pkt_t  uhost_req,
    input  logic                  uhost_resp_valid,
    input  logic                  uhost_resp_ready,
    input  tl2umi_pkg::umi_pkt_t  uhost_resp,
    input  logic                  run_done,
    output int                    error_count
);

    tl2umi_pkg::umi_pkt_t exp_req [$];
    tl2umi_pkg::tl_d_t    exp_d [$];
    logic                 busy = 1'b0;
    logic                 reported = 1'b0;
    int                   a_count = 0;
    int                   supported_count = 0;
    int                   req_count = 0;
    int                   d_count = 0;
    int                   errors = 0;

    assign error_count = errors;

    function automatic tl2umi_pkg::byte_off_t lowest_lane(input tl2umi_pkg::byte_mask_t mask);
        tl2umi_pkg::byte_off_t lane;
        logic                  found;
        lane = '0;
        found = 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (mask[i] && !found) begin
                lane = tl2umi_pkg::byte_off_t'(i);
                found = 1'b1;
            end
        end
        return lane;
    endfunction

    // Bit 8 flags a known param
    function automatic logic [8:0] atomic_type(input logic [2:0] opcode, input logic [2:0] param);
        logic [8:0] atype;
        atype = '0;
        if (opcode == `TL_A_ARITH) begin
            case (param)
                `TL_PA_MIN:  atype = {1'b1, `UMI_ATYPE_MIN};
                `TL_PA_MAX:  atype = {1'b1, `UMI_ATYPE_MAX};
                `TL_PA_MINU: atype = {1'b1, `UMI_ATYPE_MINU};
                `TL_PA_MAXU: atype = {1'b1, `UMI_ATYPE_MAXU};
                `TL_PA_ADD:  atype = {1'b1, `UMI_ATYPE_ADD};
                default:     atype = '0;
            endcase
        end else begin
            case (param)
                `TL_PL_XOR:  atype = {1'b1, `UMI_ATYPE_XOR};
                `TL_PL_OR:   atype = {1'b1, `UMI_ATYPE_OR};
                `TL_PL_AND:  atype = {1'b1, `UMI_ATYPE_AND};
                `TL_PL_SWAP: atype = {1'b1, `UMI_ATYPE_SWAP};
                default:     atype = '0;
            endcase
        end
        return atype;
    endfunction

    task automatic predict_request(input tl2umi_pkg::tl_a_t beat, output logic valid,
                                   output tl2umi_pkg::umi_pkt_t pkt);
        tl2umi_pkg::byte_off_t lane;
        logic [8:0]            atype;
        lane = lowest_lane(beat.mask);
        atype = atomic_type(beat.opcode, beat.param);
        valid = (beat.mask != '0);
        pkt = '0;
        pkt.cmd[`UMI_CMD_EOM] = 1'b1;
        pkt.dstaddr = tl2umi_pkg::umi_addr_t'(beat.address & ~tl2umi_pkg::tl_addr_t'(7))
            + tl2umi_pkg::umi_addr_t'(lane);
        pkt.srcaddr = {host_srcaddr[63:16], 1'b0, lane, 1'b0, beat.size, 3'b000, beat.source};
        pkt.data = beat.data >> (8 * lane);
        case (beat.opcode)
            `TL_A_GET: begin
                pkt.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB] = `UMI_REQ_READ;
                pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] =
                    tl2umi_pkg::umi_len_t'((1 << beat.size) - 1);
                // Read payload carries nothing
                pkt.data = '0;
            end
            `TL_A_PUTFULL, `TL_A_PUTPARTIAL: begin
                pkt.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB] = `UMI_REQ_WRITE;
                pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] =
                    tl2umi_pkg::umi_len_t'($countones(beat.mask) - 1);
            end
            `TL_A_ARITH, `TL_A_LOGICAL: begin
                pkt.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB] = `UMI_REQ_ATOMIC;
                pkt.cmd[`UMI_CMD_SIZE_MSB:`UMI_CMD_SIZE_LSB] = beat.size;
                pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] = atype[7:0];
                valid = valid && atype[8];
            end
            default: valid = 1'b0;
        endcase
    endtask

    function automatic tl2umi_pkg::tl_d_t predict_d(input tl2umi_pkg::umi_pkt_t resp);
        tl2umi_pkg::tl_d_t d;
        d = '0;
        d.source = resp.dstaddr[4:0];
        d.size = resp.dstaddr[10:8];
        if (resp.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB] == `UMI_RESP_READ) begin
            d.opcode = `TL_D_ACCESSACKDATA;
            d.data = resp.data << (8 * resp.dstaddr[14:12]);
        end else begin
            d.opcode = `TL_D_ACCESSACK;
        end
        return d;
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            errors++;
            $display("Error at %0t ns: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    // Transfers land on the next rising edge; mid-cycle values are stable
    always @(negedge clk) begin
        tl2umi_pkg::umi_pkt_t pkt;
        tl2umi_pkg::tl_d_t    d;
        logic                 valid;
        logic [4:0]           resp_op;
        if (nreset) begin
            if (tl_a_valid && tl_a_ready) begin
                a_count++;
                if (busy) begin
                    errors++;
                    $display("A beat accepted at %0t ns while a transaction was open", $time);
                end
                predict_request(tl_a, valid, pkt);
                if (valid) begin
                    exp_req.push_back(pkt);
                    supported_count++;
                    busy = 1'b1;
                end
            end
            if (uhost_req_valid && uhost_req_ready) begin
                req_count++;
                if (exp_req.size() == 0) begin
                    errors++;
                    $display("UMI request at %0t ns with no A beat behind it", $time);
                end else begin
                    pkt = exp_req.pop_front();
                    check_field("uhost_req.cmd", 64'(uhost_req.cmd), 64'(pkt.cmd));
                    check_field("uhost_req.dstaddr", uhost_req.dstaddr, pkt.dstaddr);
                    check_field("uhost_req.srcaddr", uhost_req.srcaddr, pkt.srcaddr);
                    if (pkt.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB] != `UMI_REQ_READ) begin
                        check_field("uhost_req.data", uhost_req.data, pkt.data);
                    end
                end
            end
            if (uhost_resp_valid && uhost_resp_ready) begin
                resp_op = uhost_resp.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB];
                // Other response types produce no D beat
                if (resp_op == `UMI_RESP_READ || resp_op == `UMI_RESP_WRITE) begin
                    exp_d.push_back(predict_d(uhost_resp));
                end
            end
            if (tl_d_valid && tl_d_ready) begin
                d_count++;
                busy = 1'b0;
                if (exp_d.size() == 0) begin
                    errors++;
                    $display("D beat at %0t ns with no UMI response behind it", $time);
                end else begin
                    d = exp_d.pop_front();
                    check_field("tl_d.opcode", 64'(tl_d.opcode), 64'(d.opcode));
                    check_field("tl_d.size", 64'(tl_d.size), 64'(d.size));
                    check_field("tl_d.source", 64'(tl_d.source), 64'(d.source));
                    check_field("tl_d.data", tl_d.data, d.data);
                end
            end
        end
        if (run_done && !reported) begin
            reported = 1'b1;
            if (exp_req.size() != 0 || exp_d.size() != 0 || busy) begin
                errors++;
                $display("Run ended with %0d requests and %0d D beats still expected",
                         exp_req.size(), exp_d.size());
            end
            if (req_count != supported_count) begin
                errors++;
                $display("Saw %0d UMI requests for %0d supported A beats",
                         req_count, supported_count);
            end
            $display("A beats %0d, supported %0d, UMI requests %0d, D beats %0d, errors %0d",
                     a_count, supported_count, req_count, d_count, errors);
        end
    end

endmodule

//--- logic/tl2umi.sv
// **************************************
// TL-UH to UMI host bridge, top level
// **************************************

`timescale 1ns/1ps

module tl2umi (
    input  logic                  clk,
    input  logic                  nreset,
    input  tl2umi_pkg::umi_addr_t host_srcaddr,

    input  logic                  tl_a_valid,
    output logic                  tl_a_ready,
    input  tl2umi_pkg::tl_a_t     tl_a,

    output logic                  tl_d_valid,
    input  logic                  tl_d_ready,
    output tl2umi_pkg::tl_d_t     tl_d,

    output logic                  uhost_req_valid,
    input  logic                  uhost_req_ready,
    output tl2umi_pkg::umi_pkt_t  uhost_req,

    input  logic                  uhost_resp_valid,
    output logic                  uhost_resp_ready,
    input  tl2umi_pkg::umi_pkt_t  uhost_resp
);

    logic                 pkt_valid;
    logic                 pkt_ready;
    tl2umi_pkg::umi_pkt_t pkt;
    logic                 txn_done;

    tl2umi_req req_i (
        .clk          (clk),
        .nreset       (nreset),
        .host_srcaddr (host_srcaddr),
        .tl_a_valid   (tl_a_valid),
        .tl_a_ready   (tl_a_ready),
        .tl_a         (tl_a),
        .pkt_valid    (pkt_valid),
        .pkt_ready    (pkt_ready),
        .pkt          (pkt),
        .txn_done     (txn_done)
    );

    // Decouples the request FSM from UMI back-pressure
    umi_req_fifo fifo_i (
        .clk      (clk),
        .nreset   (nreset),
        .wr_valid (pkt_valid),
        .wr_ready (pkt_ready),
        .wr_pkt   (pkt),
        .rd_valid (uhost_req_valid),
        .rd_ready (uhost_req_ready),
        .rd_pkt   (uhost_req)
    );

    tl2umi_resp resp_i (
        .clk              (clk),
        .nreset           (nreset),
        .uhost_resp_valid (uhost_resp_valid),
        .uhost_resp_ready (uhost_resp_ready),
        .uhost_resp       (uhost_resp),
        .tl_d_valid       (tl_d_valid),
        .tl_d_ready       (tl_d_ready),
        .tl_d             (tl_d),
        .txn_done         (txn_done)
    );

endmodule

//--- logic/tl2umi_resp.sv
// **************************************
// Response FSM: UMI responses to D beats
// **************************************

`timescale 1ns/1ps
`include "tl2umi_defs.svh"

module tl2umi_resp (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 uhost_resp_valid,
    output logic                 uhost_resp_ready,
    input  tl2umi_pkg::umi_pkt_t uhost_resp,
    output logic                 tl_d_valid,
    input  logic                 tl_d_ready,
    output tl2umi_pkg::tl_d_t    tl_d,
    output logic                 txn_done
);

    tl2umi_pkg::resp_state_e state;
    logic [4:0]              resp_opcode;
    tl2umi_pkg::byte_off_t   resp_offset;
    logic                    is_read;
    logic                    is_write;
    logic                    resp_fire;

    assign resp_opcode = uhost_resp.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB];
    // Offset echoed back through the request source address
    assign resp_offset = uhost_resp.dstaddr[`UMI_USR_OFF_MSB:`UMI_USR_OFF_LSB];
    assign is_read = (resp_opcode == `UMI_RESP_READ);
    assign is_write = (resp_opcode == `UMI_RESP_WRITE);

    assign uhost_resp_ready = (state == tl2umi_pkg::RESP_IDLE);
    assign tl_d_valid = (state == tl2umi_pkg::RESP_HOLD);
    assign resp_fire = uhost_resp_valid && uhost_resp_ready;
    assign txn_done = tl_d_valid && tl_d_ready;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            state <= tl2umi_pkg::RESP_IDLE;
        end else begin
            case (state)
                tl2umi_pkg::RESP_IDLE: begin
                    // Other response types are swallowed here
                    if (resp_fire && (is_read || is_write)) begin
                        state <= tl2umi_pkg::RESP_HOLD;
                    end
                end
                tl2umi_pkg::RESP_HOLD: begin
                    if (tl_d_ready) begin
                        state <= tl2umi_pkg::RESP_IDLE;
                    end
                end
                default: state <= tl2umi_pkg::RESP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (resp_fire) begin
            tl_d.source <= uhost_resp.dstaddr[`UMI_USR_SRC_MSB:`UMI_USR_SRC_LSB];
            tl_d.size <= uhost_resp.dstaddr[`UMI_USR_SIZE_MSB:`UMI_USR_SIZE_LSB];
            if (is_read) begin
                tl_d.opcode <= `TL_D_ACCESSACKDATA;
                tl_d.data <= uhost_resp.data << {resp_offset, 3'b000};
            end else begin
                tl_d.opcode <= `TL_D_ACCESSACK;
                tl_d.data <= '0;
            end
        end
    end

endmodule

//--- logic/umi_req_fifo.sv
// **************************************
// Two-entry FIFO for UMI request packets
// **************************************

`timescale 1ns/1ps

module umi_req_fifo (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 wr_valid,
    output logic                 wr_ready,
    input  tl2umi_pkg::umi_pkt_t wr_pkt,
    output logic                 rd_valid,
    input  logic                 rd_ready,
    output tl2umi_pkg::umi_pkt_t rd_pkt
);

    tl2umi_pkg::umi_pkt_t mem [0:1];
    logic                 wr_ptr;
    logic                 rd_ptr;
    logic [1:0]           count;
    logic                 wr_en;
    logic                 rd_en;

    assign wr_ready = (count != 2'd2);
    assign rd_valid = (count != 2'd0);
    assign rd_pkt = mem[rd_ptr];

    assign wr_en = wr_valid && wr_ready;
    assign rd_en = rd_valid && rd_ready;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ~wr_ptr;
            end
            if (rd_en) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, wr_en} - {1'b0, rd_en};
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_pkt;
        end
    end

endmodule

//--- logic/tl2umi_req.sv
// **************************************
// Request FSM: accepts A beats and
// builds UMI request packets
// **************************************

`timescale 1ns/1ps
`include "tl2umi_defs.svh"

module tl2umi_req (
    input  logic                  clk,
    input  logic                  nreset,
    input  tl2umi_pkg::umi_addr_t host_srcaddr,
    input  logic                  tl_a_valid,
    output logic                  tl_a_ready,
    input  tl2umi_pkg::tl_a_t     tl_a,
    output logic                  pkt_valid,
    input  logic                  pkt_ready,
    output tl2umi_pkg::umi_pkt_t  pkt,
    input  logic                  txn_done
);

    tl2umi_pkg::req_state_e state;
    logic [1:0]             reset_done;
    tl2umi_pkg::byte_off_t  offset;
    tl2umi_pkg::umi_len_t   mask_len;
    tl2umi_pkg::umi_addr_t  aligned_addr;
    tl2umi_pkg::data_t      shifted_data;
    logic                   mask_zero;
    logic                   supported;
    logic                   a_fire;
    tl2umi_pkg::umi_pkt_t   next_pkt;

    tl_mask_convert mask_i (
        .mask         (tl_a.mask),
        .address      (tl_a.address),
        .data         (tl_a.data),
        .offset       (offset),
        .len          (mask_len),
        .aligned_addr (aligned_addr),
        .shifted_data (shifted_data),
        .mask_zero    (mask_zero)
    );

    always_comb begin
        supported = 1'b1;
        next_pkt = '0;
        next_pkt.cmd[`UMI_CMD_EOM] = 1'b1;
        next_pkt.dstaddr = aligned_addr;
        next_pkt.data = shifted_data;
        // Route-back info for the response path
        next_pkt.srcaddr[`TL2UMI_AW-1:`UMI_USR_HOST_LSB] =
            host_srcaddr[`TL2UMI_AW-1:`UMI_USR_HOST_LSB];
        next_pkt.srcaddr[`UMI_USR_OFF_MSB:`UMI_USR_OFF_LSB] = offset;
        next_pkt.srcaddr[`UMI_USR_SIZE_MSB:`UMI_USR_SIZE_LSB] = tl_a.size;
        next_pkt.srcaddr[`UMI_USR_SRC_MSB:`UMI_USR_SRC_LSB] = tl_a.source;
        case (tl_a.opcode)
            `TL_A_GET: begin
                next_pkt.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB] = `UMI_REQ_READ;
                next_pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] =
                    (tl2umi_pkg::umi_len_t'(1) << tl_a.size) - 8'd1;
            end
            `TL_A_PUTFULL, `TL_A_PUTPARTIAL: begin
                next_pkt.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB] = `UMI_REQ_WRITE;
                next_pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] = mask_len;
            end
            `TL_A_ARITH: begin
                next_pkt.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB] = `UMI_REQ_ATOMIC;
                next_pkt.cmd[`UMI_CMD_SIZE_MSB:`UMI_CMD_SIZE_LSB] = tl_a.size;
                case (tl_a.param)
                    `TL_PA_MIN:  next_pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] = `UMI_ATYPE_MIN;
                    `TL_PA_MAX:  next_pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] = `UMI_ATYPE_MAX;
                    `TL_PA_MINU: next_pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] = `UMI_ATYPE_MINU;
                    `TL_PA_MAXU: next_pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] = `UMI_ATYPE_MAXU;
                    `TL_PA_ADD:  next_pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] = `UMI_ATYPE_ADD;
                    default:     supported = 1'b0;
                endcase
            end
            `TL_A_LOGICAL: begin
                next_pkt.cmd[`UMI_CMD_OP_MSB:`UMI_CMD_OP_LSB] = `UMI_REQ_ATOMIC;
                next_pkt.cmd[`UMI_CMD_SIZE_MSB:`UMI_CMD_SIZE_LSB] = tl_a.size;
                case (tl_a.param)
                    `TL_PL_XOR:  next_pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] = `UMI_ATYPE_XOR;
                    `TL_PL_OR:   next_pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] = `UMI_ATYPE_OR;
                    `TL_PL_AND:  next_pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] = `UMI_ATYPE_AND;
                    `TL_PL_SWAP: next_pkt.cmd[`UMI_CMD_LEN_MSB:`UMI_CMD_LEN_LSB] = `UMI_ATYPE_SWAP;
                    default:     supported = 1'b0;
                endcase
            end
            default: supported = 1'b0;
        endcase
        // Nothing to access with an empty mask
        if (mask_zero) begin
            supported = 1'b0;
        end
    end

    assign tl_a_ready = reset_done[1] && (state == tl2umi_pkg::REQ_IDLE);
    assign a_fire = tl_a_valid && tl_a_ready;
    assign pkt_valid = (state == tl2umi_pkg::REQ_SEND);

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            reset_done <= 2'b00;
            state <= tl2umi_pkg::REQ_IDLE;
        end else begin
            reset_done <= {reset_done[0], 1'b1};
            case (state)
                tl2umi_pkg::REQ_IDLE: begin
                    if (a_fire && supported) begin
                        state <= tl2umi_pkg::REQ_SEND;
                    end
                end
                tl2umi_pkg::REQ_SEND: begin
                    if (pkt_ready) begin
                        state <= tl2umi_pkg::REQ_WAIT;
                    end
                end
                tl2umi_pkg::REQ_WAIT: begin
                    if (txn_done) begin
                        state <= tl2umi_pkg::REQ_IDLE;
                    end
                end
                default: state <= tl2umi_pkg::REQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (a_fire) begin
            pkt <= next_pkt;
        end
    end

endmodule

//--- logic/tl_mask_convert.sv
// **************************************
// TL byte mask to maskless UMI access:
// offset, length, address and data
// **************************************

`timescale 1ns/1ps
`include "tl2umi_defs.svh"

module tl_mask_convert (
    input  tl2umi_pkg::byte_mask_t mask,
    input  tl2umi_pkg::tl_addr_t   address,
    input  tl2umi_pkg::data_t      data,
    output tl2umi_pkg::byte_off_t  offset,
    output tl2umi_pkg::umi_len_t   len,
    output tl2umi_pkg::umi_addr_t  aligned_addr,
    output tl2umi_pkg::data_t      shifted_data,
    output logic                   mask_zero
);

    tl2umi_pkg::umi_len_t ones;

    // Lowest set bit wins, so scan from the top down
    always_comb begin
        offset = '0;
        for (int i = 7; i >= 0; i--) begin
            if (mask[i]) begin
                offset = tl2umi_pkg::byte_off_t'(i);
            end
        end
    end

    always_comb begin
        ones = '0;
        for (int i = 0; i < 8; i++) begin
            ones = ones + tl2umi_pkg::umi_len_t'(mask[i]);
        end
    end

    assign len = ones - 8'd1;
    assign mask_zero = ~|mask;

    assign aligned_addr = tl2umi_pkg::umi_addr_t'({address[`TL2UMI_TLAW-1:3], offset});
    assign shifted_data = data >> {offset, 3'b000};

endmodule

//--- logic/tl2umi_pkg.sv
// **************************************
// Bridge types: field vectors, A and D
// beats, UMI packet and FSM states
// **************************************

`include "tl2umi_defs.svh"

package tl2umi_pkg;

    typedef logic [`TL2UMI_DW-1:0]   data_t;
    typedef logic [`TL2UMI_AW-1:0]   umi_addr_t;
    typedef logic [`TL2UMI_TLAW-1:0] tl_addr_t;
    typedef logic [`TL2UMI_CW-1:0]   umi_cmd_t;
    typedef logic [`TL2UMI_SRCW-1:0] tl_source_t;

    // log2 of the byte count
    typedef logic [2:0] tl_size_t;
    typedef logic [`TL2UMI_DW/8-1:0] byte_mask_t;
    typedef logic [2:0] byte_off_t;
    // Byte count minus one
    typedef logic [7:0] umi_len_t;

    typedef struct packed {
        logic [2:0] opcode;
        logic [2:0] param;
        tl_size_t   size;
        tl_source_t source;
        tl_addr_t   address;
        byte_mask_t mask;
        data_t      data;
    } tl_a_t;

    typedef struct packed {
        logic [2:0] opcode;
        tl_size_t   size;
        tl_source_t source;
        data_t      data;
    } tl_d_t;

    typedef struct packed {
        umi_cmd_t  cmd;
        umi_addr_t dstaddr;
        umi_addr_t srcaddr;
        data_t     data;
    } umi_pkt_t;

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_SEND,
        REQ_WAIT
    } req_state_e;

    typedef enum logic {
        RESP_IDLE,
        RESP_HOLD
    } resp_state_e;

endpackage

//--- include/tl2umi_defs.svh
// **************************************
// Widths, TL and UMI opcode encodings,
// atomic params and command field bits
// **************************************

`ifndef TL2UMI_DEFS_SVH
`define TL2UMI_DEFS_SVH

`define TL2UMI_CW   32
`define TL2UMI_AW   64
`define TL2UMI_DW   64
`define TL2UMI_TLAW 56
`define TL2UMI_SRCW 5

// TL A channel opcodes
`define TL_A_PUTFULL    3'd0
`define TL_A_PUTPARTIAL 3'd1
`define TL_A_ARITH      3'd2
`define TL_A_LOGICAL    3'd3
`define TL_A_GET        3'd4

// TL D channel opcodes
`define TL_D_ACCESSACK     3'd0
`define TL_D_ACCESSACKDATA 3'd1

// Arithmetic params
`define TL_PA_MIN  3'd0
`define TL_PA_MAX  3'd1
`define TL_PA_MINU 3'd2
`define TL_PA_MAXU 3'd3
`define TL_PA_ADD  3'd4

// Logical params
`define TL_PL_XOR  3'd0
`define TL_PL_OR   3'd1
`define TL_PL_AND  3'd2
`define TL_PL_SWAP 3'd3

`define UMI_REQ_READ   5'd1
`define UMI_REQ_WRITE  5'd3
`define UMI_REQ_ATOMIC 5'd9
`define UMI_RESP_READ  5'd2
`define UMI_RESP_WRITE 5'd4

// UMI atomic types
`define UMI_ATYPE_ADD  8'd0
`define UMI_ATYPE_AND  8'd1
`define UMI_ATYPE_OR   8'd2
`define UMI_ATYPE_XOR  8'd3
`define UMI_ATYPE_MAX  8'd4
`define UMI_ATYPE_MIN  8'd5
`define UMI_ATYPE_MAXU 8'd6
`define UMI_ATYPE_MINU 8'd7
`define UMI_ATYPE_SWAP 8'd8

// Command fields
`define UMI_CMD_OP_MSB   4
`define UMI_CMD_OP_LSB   0
`define UMI_CMD_SIZE_MSB 7
`define UMI_CMD_SIZE_LSB 5
`define UMI_CMD_LEN_MSB  15
`define UMI_CMD_LEN_LSB  8
`define UMI_CMD_EOM      22

// User bits of the source address
`define UMI_USR_SRC_MSB  4
`define UMI_USR_SRC_LSB  0
`define UMI_USR_SIZE_MSB 10
`define UMI_USR_SIZE_LSB 8
`define UMI_USR_OFF_MSB  14
`define UMI_USR_OFF_LSB  12
`define UMI_USR_HOST_LSB 16

`endif
